// File: verilog.f
+incdir+hdl
hdl/matmul_pkg.sv
hdl/operand_if.sv
hdl/proc_element.sv
hdl/systolic_array.sv
hdl/operand_feeder.sv
hdl/result_drain.sv
hdl/matmul_top.sv
bench/matmul_tb.sv

// File: bench/matmul_tb.sv
`timescale 1ns/1ps
`include "matmul_defs.svh"

module matmul_tb;

    localparam int DIM           = `MATMUL_ARRAY_DIM;
    localparam int BEAT_TIMEOUT  = 500;
    localparam int IDLE_TIMEOUT  = 2000;
    localparam int DRAIN_TIMEOUT = 4000;

    logic                     clk = 1'b0;
    logic                     reset_n;
    logic                     start_i;
    logic [`MATMUL_K_W-1:0]   k_len_i;
    logic                     a_valid_i;
    matmul_pkg::operand_vec_t a_data_i;
    logic                     a_ready_o;
    logic                     b_valid_i;
    matmul_pkg::operand_vec_t b_data_i;
    logic                     b_ready_o;
    logic                     c_valid_o;
    matmul_pkg::acc_row_t     c_data_o;
    logic                     c_last_o;
    logic                     c_ready_i;
    logic                     busy_o;

    // beat k carries column k of A and row k of B
    matmul_pkg::operand_vec_t a_cols [256];
    matmul_pkg::operand_vec_t b_rows [256];
    matmul_pkg::acc_row_t     expected_rows [$];
    matmul_pkg::acc_row_t     expected;
    matmul_pkg::acc_row_t     held_data;
    logic                     held_last;
    logic                     prev_valid;
    logic                     stall_seen;

    int mismatch_count = 0;
    int failure_count  = 0;
    int jobs_issued    = 0;
    int handoffs       = 0;
    int rows_seen      = 0;
    int row_idx        = 0;
    int overlaps       = 0;
    int ready_mode     = 0;
    bit aborted        = 1'b0;

    matmul_top i_matmul_top (
        .clk       ( clk       ),
        .reset_n   ( reset_n   ),
        .start_i   ( start_i   ),
        .k_len_i   ( k_len_i   ),
        .a_valid_i ( a_valid_i ),
        .a_data_i  ( a_data_i  ),
        .a_ready_o ( a_ready_o ),
        .b_valid_i ( b_valid_i ),
        .b_data_i  ( b_data_i  ),
        .b_ready_o ( b_ready_o ),
        .c_valid_o ( c_valid_o ),
        .c_data_o  ( c_data_o  ),
        .c_last_o  ( c_last_o  ),
        .c_ready_i ( c_ready_i ),
        .busy_o    ( busy_o    )
    );

    always #2 clk = ~clk;

    // C[i][j] = sum over k of A[i][k] * B[k][j], wrapped to 16 bits
    function automatic matmul_pkg::acc_matrix_t reference_product(input int k);
        matmul_pkg::acc_matrix_t c;
        int                      sum;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                sum = 0;
                for (int kk = 0; kk < k; kk++) begin
                    sum = (sum + int'(a_cols[kk][i]) * int'(b_rows[kk][j])) % 65536;
                end
                c[i][j] = matmul_pkg::acc_t'(sum);
            end
        end
        return c;
    endfunction

    task automatic check_bit(input string name, input logic actual, input logic want);
        assert (actual === want) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, want, actual);
        end
    endtask

    task automatic fill_operands(input int k, input bit all_max);
        for (int kk = 0; kk < k; kk++) begin
            for (int e = 0; e < DIM; e++) begin
                a_cols[kk][e] = all_max ? 8'hff : matmul_pkg::elem_t'($urandom_range(255));
                b_rows[kk][e] = all_max ? 8'hff : matmul_pkg::elem_t'($urandom_range(255));
            end
        end
    endtask

    // feeder is idle once every started job has handed off to the drain
    task automatic wait_feeder_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (handoffs != jobs_issued) begin
            if (cycles == IDLE_TIMEOUT) begin
                failure_count++;
                aborted = 1'b1;
                $display("%0t: timeout, job %0d never reached the drain", $time, handoffs);
                return;
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_all_drained();
        int cycles;
        cycles = 0;
        while (rows_seen != jobs_issued * DIM) begin
            if (cycles == DRAIN_TIMEOUT) begin
                failure_count++;
                aborted = 1'b1;
                $display("%0t: timeout, only %0d result rows of %0d arrived",
                         $time, rows_seen, jobs_issued * DIM);
                return;
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic run_job(input int k, input bit all_max, input bit gaps, input bit poke);
        int                      beat;
        int                      stall;
        bit                      xfer;
        bit                      poked;
        matmul_pkg::acc_matrix_t c_ref;
        if (aborted) begin
            return;
        end
        fill_operands(k, all_max);
        wait_feeder_idle();
        if (aborted) begin
            return;
        end
        if (c_valid_o) begin
            overlaps++;
        end
        c_ref = reference_product(k);
        for (int r = 0; r < DIM; r++) begin
            expected_rows.push_back(c_ref[r]);
        end
        start_i = 1'b1;
        k_len_i = `MATMUL_K_W'(k);
        @(negedge clk);
        start_i = 1'b0;
        check_bit("busy_o", busy_o, 1'b1);
        jobs_issued++;
        beat  = 0;
        stall = 0;
        xfer  = 1'b0;
        poked = 1'b0;
        while (beat < k) begin
            if (xfer) begin
                a_valid_i = 1'b0;
                b_valid_i = 1'b0;
            end
            // a raised valid holds until the beat transfers
            if (!a_valid_i) begin
                a_valid_i = gaps ? ($urandom_range(2) != 0) : 1'b1;
            end
            if (!b_valid_i) begin
                b_valid_i = gaps ? ($urandom_range(2) != 0) : 1'b1;
            end
            a_data_i = a_valid_i ? a_cols[beat] : $urandom();
            b_data_i = b_valid_i ? b_rows[beat] : $urandom();
            // start during load must be ignored
            if (poke && !poked && beat > 0 && beat == k / 2) begin
                start_i = 1'b1;
                k_len_i = `MATMUL_K_W'(k + 3);
                poked   = 1'b1;
            end else begin
                start_i = 1'b0;
            end
            @(posedge clk);
            xfer = a_valid_i && b_valid_i && a_ready_o;
            if (xfer) begin
                beat++;
                stall = 0;
            end else begin
                stall++;
                if (stall == BEAT_TIMEOUT) begin
                    failure_count++;
                    aborted = 1'b1;
                    $display("%0t: timeout, operand beat %0d of %0d was never accepted",
                             $time, beat, k);
                    return;
                end
            end
            @(negedge clk);
        end
        start_i   = 1'b0;
        a_valid_i = 1'b0;
        b_valid_i = 1'b0;
    endtask

    // result side back-pressure
    initial begin
        c_ready_i = 1'b0;
        forever begin
            @(negedge clk);
            case (ready_mode)
                0: c_ready_i = 1'b1;
                1: c_ready_i = ($urandom_range(1) != 0);
                default: c_ready_i = ($urandom_range(3) == 0);
            endcase
        end
    end

    always @(posedge clk) begin
        if (!reset_n) begin
            prev_valid = 1'b0;
            stall_seen = 1'b0;
            row_idx    = 0;
        end else begin
            assert (a_ready_o === b_ready_o) else begin
                failure_count++;
                $display("%0t: a_ready_o and b_ready_o differ", $time);
            end
            if (stall_seen) begin
                assert (c_valid_o) else begin
                    failure_count++;
                    $display("%0t: c_valid_o dropped before the stalled row was taken", $time);
                end
                assert (c_data_o === held_data) else begin
                    mismatch_count++;
                    $display("mismatch at %0t: c_data_o expected %h actual %h",
                             $time, held_data, c_data_o);
                end
                check_bit("c_last_o", c_last_o, held_last);
            end
            if (c_valid_o && !prev_valid) begin
                handoffs++;
            end
            if (c_valid_o && c_ready_i) begin
                if (expected_rows.size() == 0) begin
                    failure_count++;
                    $display("%0t: result row arrived with no job outstanding", $time);
                end else begin
                    expected = expected_rows.pop_front();
                    assert (c_data_o === expected) else begin
                        mismatch_count++;
                        $display("mismatch at %0t: c_data_o expected %h actual %h",
                                 $time, expected, c_data_o);
                    end
                end
                check_bit("c_last_o", c_last_o, row_idx == DIM - 1);
                row_idx = (row_idx + 1) % DIM;
                rows_seen++;
            end
            stall_seen = c_valid_o && !c_ready_i;
            held_data  = c_data_o;
            held_last  = c_last_o;
            prev_valid = c_valid_o;
        end
    end

    initial begin
        int overlap_mark;
        void'($urandom(90921));
        reset_n   = 1'b0;
        start_i   = 1'b0;
        k_len_i   = '0;
        a_valid_i = 1'b0;
        a_data_i  = '0;
        b_valid_i = 1'b0;
        b_data_i  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_bit("a_ready_o", a_ready_o, 1'b0);
        check_bit("c_valid_o", c_valid_o, 1'b0);
        check_bit("c_last_o", c_last_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);

        ready_mode = 0;
        repeat (20) run_job($urandom_range(16, 1), 1'b0, 1'b0, 1'b0);
        repeat (20) run_job($urandom_range(16, 1), 1'b0, 1'b1, 1'b0);

        // stalls on the result side
        ready_mode = 1;
        repeat (15) run_job($urandom_range(16, 1), 1'b0, 1'b1, 1'b0);
        ready_mode = 2;
        repeat (10) run_job($urandom_range(16, 1), 1'b0, 1'b1, 1'b0);

        // short jobs against a slow drain, so loads overlap draining
        overlap_mark = overlaps;
        repeat (6) run_job($urandom_range(4, 1), 1'b0, 1'b0, 1'b0);
        assert (aborted || overlaps > overlap_mark) else begin
            failure_count++;
            $display("%0t: no job started while a previous result was draining", $time);
        end

        ready_mode = 1;
        run_job(1, 1'b0, 1'b1, 1'b0);
        run_job(0, 1'b0, 1'b1, 1'b0);
        run_job(255, 1'b1, 1'b1, 1'b0);
        run_job(12, 1'b0, 1'b1, 1'b1);

        if (!aborted) begin
            wait_all_drained();
        end
        if (!aborted) begin
            @(negedge clk);
            check_bit("busy_o", busy_o, 1'b0);
            assert (expected_rows.size() == 0) else begin
                failure_count++;
                $display("%0t: %0d expected rows never arrived", $time, expected_rows.size());
            end
        end

        $display("error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: hdl/matmul_top.sv
`timescale 1ns/1ps
`include "matmul_defs.svh"

module matmul_top (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start_i,
    input  logic [`MATMUL_K_W-1:0]   k_len_i,
    input  logic                     a_valid_i,
    input  matmul_pkg::operand_vec_t a_data_i,
    output logic                     a_ready_o,
    input  logic                     b_valid_i,
    input  matmul_pkg::operand_vec_t b_data_i,
    output logic                     b_ready_o,
    output logic                     c_valid_o,
    output matmul_pkg::acc_row_t     c_data_o,
    output logic                     c_last_o,
    input  logic                     c_ready_i,
    output logic                     busy_o
);

    logic                    ready;
    logic                    compute_done;
    logic                    drain_busy;
    matmul_pkg::acc_matrix_t acc;

    operand_if ops_if ();

    // both operand streams share one ready
    assign a_ready_o = ready;
    assign b_ready_o = ready;

    operand_feeder i_operand_feeder (
        .clk            ( clk          ),
        .reset_n        ( reset_n      ),
        .start_i        ( start_i      ),
        .k_len_i        ( k_len_i      ),
        .a_valid_i      ( a_valid_i    ),
        .b_valid_i      ( b_valid_i    ),
        .a_data_i       ( a_data_i     ),
        .b_data_i       ( b_data_i     ),
        .ready_o        ( ready        ),
        .ops            ( ops_if       ),
        .drain_busy_i   ( drain_busy   ),
        .compute_done_o ( compute_done ),
        .busy_o         ( busy_o       )
    );

    systolic_array i_systolic_array (
        .clk     ( clk     ),
        .reset_n ( reset_n ),
        .ops     ( ops_if  ),
        .acc_o   ( acc     )
    );

    result_drain i_result_drain (
        .clk            ( clk          ),
        .reset_n        ( reset_n      ),
        .acc_i          ( acc          ),
        .compute_done_i ( compute_done ),
        .drain_busy_o   ( drain_busy   ),
        .c_valid_o      ( c_valid_o    ),
        .c_ready_i      ( c_ready_i    ),
        .c_data_o       ( c_data_o     ),
        .c_last_o       ( c_last_o     )
    );

endmodule

// File: hdl/result_drain.sv
`timescale 1ns/1ps
`include "matmul_defs.svh"

module result_drain (
    input  logic                    clk,
    input  logic                    reset_n,
    input  matmul_pkg::acc_matrix_t acc_i,
    input  logic                    compute_done_i,
    output logic                    drain_busy_o,
    output logic                    c_valid_o,
    input  logic                    c_ready_i,
    output matmul_pkg::acc_row_t    c_data_o,
    output logic                    c_last_o
);

    localparam int ROW_W = $clog2(`MATMUL_ARRAY_DIM);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`MATMUL_ARRAY_DIM - 1);

    matmul_pkg::acc_matrix_t snap_q;
    logic [ROW_W-1:0]        row_q;
    logic                    draining_q;
    logic                    row_done;

    assign row_done     = draining_q && c_ready_i;
    assign c_valid_o    = draining_q;
    assign drain_busy_o = draining_q;
    assign c_data_o     = snap_q[row_q];
    assign c_last_o     = draining_q && (row_q == LAST_ROW);

    // frees the array for the next job
    always_ff @(posedge clk) begin
        if (compute_done_i) begin
            snap_q <= acc_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            draining_q <= 1'b0;
            row_q      <= '0;
        end else if (compute_done_i) begin
            draining_q <= 1'b1;
            row_q      <= '0;
        end else if (row_done) begin
            if (row_q == LAST_ROW) begin
                draining_q <= 1'b0;
            end else begin
                row_q <= row_q + 1'b1;
            end
        end
    end

    no_done_while_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        compute_done_i |-> !draining_q
    );

    // stalled row holds until taken
    stable_while_stalled: assert property (
        @(posedge clk) disable iff (!reset_n)
        c_valid_o && !c_ready_i |=> c_valid_o && $stable(c_data_o) && $stable(c_last_o)
    );

endmodule

// File: hdl/operand_feeder.sv
`timescale 1ns/1ps
`include "matmul_defs.svh"

module operand_feeder (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start_i,
    input  logic [`MATMUL_K_W-1:0]   k_len_i,
    input  logic                     a_valid_i,
    input  logic                     b_valid_i,
    input  matmul_pkg::operand_vec_t a_data_i,
    input  matmul_pkg::operand_vec_t b_data_i,
    output logic                     ready_o,
    operand_if.src                   ops,
    input  logic                     drain_busy_i,
    output logic                     compute_done_o,
    output logic                     busy_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_LOAD,
        ST_FLUSH,
        ST_HANDOFF
    } state_t;

    localparam logic [`MATMUL_K_W-1:0] FLUSH_LAST = `MATMUL_K_W'(`MATMUL_FLUSH_STEPS - 1);

    state_t                 state_q;
    logic [`MATMUL_K_W-1:0] k_len_q;
    logic [`MATMUL_K_W-1:0] step_cnt_q;
    logic                   loading;
    logic                   beat;
    matmul_pkg::elem_t      a_lane [`MATMUL_ARRAY_DIM];
    matmul_pkg::elem_t      b_lane [`MATMUL_ARRAY_DIM];

    assign loading        = (state_q == ST_LOAD);
    assign ready_o        = loading;
    assign beat           = loading && a_valid_i && b_valid_i;
    assign ops.step       = beat || (state_q == ST_FLUSH);
    assign ops.clear      = (state_q == ST_CLEAR);
    assign compute_done_o = (state_q == ST_HANDOFF) && !drain_busy_i;
    // a job stays busy until its last row has left the drain
    assign busy_o         = (state_q != ST_IDLE) || drain_busy_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= ST_IDLE;
            step_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    step_cnt_q <= '0;
                    state_q    <= (k_len_q == '0) ? ST_FLUSH : ST_LOAD;
                end
                ST_LOAD: begin
                    if (beat) begin
                        if (step_cnt_q == k_len_q - 1'b1) begin
                            step_cnt_q <= '0;
                            state_q    <= ST_FLUSH;
                        end else begin
                            step_cnt_q <= step_cnt_q + 1'b1;
                        end
                    end
                end
                ST_FLUSH: begin
                    if (step_cnt_q == FLUSH_LAST) begin
                        step_cnt_q <= '0;
                        state_q    <= ST_HANDOFF;
                    end else begin
                        step_cnt_q <= step_cnt_q + 1'b1;
                    end
                end
                ST_HANDOFF: begin
                    if (!drain_busy_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && start_i) begin
            k_len_q <= k_len_i;
        end
    end

    for (genvar lane = 0; lane < `MATMUL_ARRAY_DIM; lane++) begin : g_lane
        matmul_pkg::elem_t a_in;
        matmul_pkg::elem_t b_in;

        // zeros outside load push the last beats through
        assign a_in = loading ? a_data_i[lane] : '0;
        assign b_in = loading ? b_data_i[lane] : '0;

        if (lane == 0) begin : g_direct
            assign a_lane[lane] = a_in;
            assign b_lane[lane] = b_in;
        end else begin : g_delay
            matmul_pkg::elem_t a_pipe [lane];
            matmul_pkg::elem_t b_pipe [lane];

            always_ff @(posedge clk) begin
                if (ops.clear) begin
                    for (int s = 0; s < lane; s++) begin
                        a_pipe[s] <= '0;
                        b_pipe[s] <= '0;
                    end
                end else if (ops.step) begin
                    a_pipe[0] <= a_in;
                    b_pipe[0] <= b_in;
                    for (int s = 1; s < lane; s++) begin
                        a_pipe[s] <= a_pipe[s-1];
                        b_pipe[s] <= b_pipe[s-1];
                    end
                end
            end

            assign a_lane[lane] = a_pipe[lane-1];
            assign b_lane[lane] = b_pipe[lane-1];
        end
    end

    always_comb begin
        for (int lane = 0; lane < `MATMUL_ARRAY_DIM; lane++) begin
            ops.a_skew[lane] = a_lane[lane];
            ops.b_skew[lane] = b_lane[lane];
        end
    end

    // steps only while beats or flush steps of the job remain
    step_only_when_running: assert property (
        @(posedge clk) disable iff (!reset_n)
        ops.step |-> (loading && (step_cnt_q < k_len_q))
                     || ((state_q == ST_FLUSH) && (step_cnt_q <= FLUSH_LAST))
    );

    // the drain must take the snapshot and report busy right after
    done_waits_for_drain: assert property (
        @(posedge clk) disable iff (!reset_n)
        compute_done_o |-> !drain_busy_i ##1 drain_busy_i
    );

endmodule

// File: hdl/systolic_array.sv
`timescale 1ns/1ps
`include "matmul_defs.svh"

module systolic_array (
    input  logic                    clk,
    input  logic                    reset_n,
    operand_if.dst                  ops,
    output matmul_pkg::acc_matrix_t acc_o
);

    localparam int DIM = `MATMUL_ARRAY_DIM;

    // horizontal a links with column DIM as the right edge
    matmul_pkg::elem_t a_link   [DIM][DIM+1];
    // vertical b links with row DIM as the bottom edge
    matmul_pkg::elem_t b_link   [DIM+1][DIM];
    matmul_pkg::acc_t  acc_cell [DIM][DIM];

    for (genvar e = 0; e < DIM; e++) begin : g_edge
        assign a_link[e][0] = ops.a_skew[e];
        assign b_link[0][e] = ops.b_skew[e];
    end

    for (genvar r = 0; r < DIM; r++) begin : g_row
        for (genvar c = 0; c < DIM; c++) begin : g_col
            proc_element i_proc_element (
                .clk     ( clk              ),
                .reset_n ( reset_n          ),
                .step_i  ( ops.step         ),
                .clear_i ( ops.clear        ),
                .a_i     ( a_link[r][c]     ),
                .b_i     ( b_link[r][c]     ),
                .a_o     ( a_link[r][c+1]   ),
                .b_o     ( b_link[r+1][c]   ),
                .acc_o   ( acc_cell[r][c]   )
            );
        end
    end

    always_comb begin
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                acc_o[r][c] = acc_cell[r][c];
            end
        end
    end

    // flush pushes zeros through, so nothing is left at the edges afterwards
    edges_drain_to_zero: assert property (
        @(posedge clk) disable iff (!reset_n)
        ops.clear |-> (a_link[DIM-1][DIM] == '0) && (b_link[DIM][DIM-1] == '0)
    );

endmodule

// File: hdl/proc_element.sv
`timescale 1ns/1ps

module proc_element (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              step_i,
    input  logic              clear_i,
    input  matmul_pkg::elem_t a_i,
    input  matmul_pkg::elem_t b_i,
    output matmul_pkg::elem_t a_o,
    output matmul_pkg::elem_t b_o,
    output matmul_pkg::acc_t  acc_o
);

    matmul_pkg::acc_t product;

    // full 16 bit product, the sum wraps
    assign product = matmul_pkg::acc_t'(a_i) * matmul_pkg::acc_t'(b_i);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else if (clear_i) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else if (step_i) begin
            // a moves right, b moves down
            a_o   <= a_i;
            b_o   <= b_i;
            acc_o <= acc_o + product;
        end
    end

endmodule

// File: hdl/operand_if.sv
`timescale 1ns/1ps

interface operand_if;

    // row i of A and column j of B arrive already delayed by i and j steps
    matmul_pkg::operand_vec_t a_skew;
    matmul_pkg::operand_vec_t b_skew;
    logic                     step;
    logic                     clear;

    modport src (
        output a_skew,
        output b_skew,
        output step,
        output clear
    );

    modport dst (
        input a_skew,
        input b_skew,
        input step,
        input clear
    );

endinterface

// File: hdl/matmul_pkg.sv
`include "matmul_defs.svh"

package matmul_pkg;

    typedef logic [`MATMUL_ELEM_W-1:0] elem_t;

    // one column of A or one row of B, element 0 in the low byte
    typedef elem_t [`MATMUL_ARRAY_DIM-1:0] operand_vec_t;

    typedef logic [`MATMUL_ACC_W-1:0] acc_t;

    // one row of C, column 0 in the low word
    typedef acc_t [`MATMUL_ARRAY_DIM-1:0] acc_row_t;

    typedef acc_row_t [`MATMUL_ARRAY_DIM-1:0] acc_matrix_t;

endpackage

// File: hdl/matmul_defs.svh
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// array is square, rows equal columns
`define MATMUL_ARRAY_DIM 4
`define MATMUL_ELEM_W 8
`define MATMUL_ACC_W 16
`define MATMUL_K_W 8

// zero steps after the last beat until it reaches the far corner
`define MATMUL_FLUSH_STEPS (2 * `MATMUL_ARRAY_DIM - 1)

`endif
